/* common/cpuPkg.sv */
// CPU shared definitions
`default_nettype none

package cpuPkg;

    // Datapath and memory sizes
    localparam int dataWidth = 32;
    localparam int imemDepth = 64;
    localparam int imemAddrBits = 6;
    localparam int dmemDepth = 64;
    localparam int dmemAddrBits = 6;

    // Major opcodes
    localparam logic [5:0] opRType = 6'd4;
    localparam logic [5:0] opAddiu = 6'd12;
    localparam logic [5:0] opSubiu = 6'd13;
    localparam logic [5:0] opSw = 6'd16;
    localparam logic [5:0] opLw = 6'd17;
    localparam logic [5:0] opBeq = 6'd19;
    localparam logic [5:0] opJ = 6'd28;

    // R-format function codes
    localparam logic [5:0] fnAdd = 6'd32;
    localparam logic [5:0] fnSub = 6'd34;
    localparam logic [5:0] fnAnd = 6'd36;
    localparam logic [5:0] fnOr = 6'd37;
    localparam logic [5:0] fnSlt = 6'd42;

    // ALUOp class from the main decoder
    localparam logic [1:0] aluOpSub = 2'b00; // beq compare, subiu
    localparam logic [1:0] aluOpAdd = 2'b01; // addiu, address calc
    localparam logic [1:0] aluOpFunct = 2'b10; // Defer to funct field

    // ALU operation select
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;

    // One instruction word seen as R format or as I/J format
    typedef union packed {
        struct packed {
            logic [5:0] opCode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] opCode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [15:0] imm; // Jump target also spans rs, rt and imm
        } i;
    } instrT;

endpackage

`default_nettype wire

/* control/control.sv */
// Main control decoder
`timescale 1ns/1ps
`default_nettype none

module control (
    input wire [5:0] opCode,
    output logic regWrite,
    output logic [1:0] aluOp,
    output logic regDst,
    output logic aluSrc,
    output logic memWrite,
    output logic memRead,
    output logic memToReg,
    output logic jump,
    output logic branch
);

    // Each branch sets {regWrite, aluOp, regDst, aluSrc} then the memory and flow bits
    always_comb
    begin
        case (opCode)
            cpuPkg::opRType:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b1, cpuPkg::aluOpFunct, 2'b10};
                {memWrite, memRead, memToReg, jump, branch} = 5'b00000;
            end
            cpuPkg::opAddiu:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b1, cpuPkg::aluOpAdd, 2'b01}; // Into rt
                {memWrite, memRead, memToReg, jump, branch} = 5'b00000;
            end
            cpuPkg::opSubiu:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b1, cpuPkg::aluOpSub, 2'b01}; // Into rt
                {memWrite, memRead, memToReg, jump, branch} = 5'b00000;
            end
            cpuPkg::opSw:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b0, cpuPkg::aluOpAdd, 2'b01};
                {memWrite, memRead, memToReg, jump, branch} = 5'b10000; // Store only
            end
            cpuPkg::opLw:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b1, cpuPkg::aluOpAdd, 2'b01};
                {memWrite, memRead, memToReg, jump, branch} = 5'b01100; // Load to rt
            end
            cpuPkg::opBeq:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b0, cpuPkg::aluOpSub, 2'b00};
                {memWrite, memRead, memToReg, jump, branch} = 5'b00001; // Compare rs, rt
            end
            cpuPkg::opJ:
            begin
                {regWrite, aluOp, regDst, aluSrc} = {1'b0, cpuPkg::aluOpSub, 2'b01};
                {memWrite, memRead, memToReg, jump, branch} = 5'b00010;
            end
            default:
            begin
                // Unknown opcode acts as a no-op that still advances the PC
                {regWrite, aluOp, regDst, aluSrc} = {1'b0, cpuPkg::aluOpSub, 2'b00};
                {memWrite, memRead, memToReg, jump, branch} = 5'b00000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/aluControl.sv */
// ALU control and ALU
`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input wire [1:0] aluOp,
    input wire [5:0] funct,
    input wire [cpuPkg::dataWidth-1:0] a,
    input wire [cpuPkg::dataWidth-1:0] b,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic zero
);

    logic [2:0] aluSel;
    logic aluSelValid;

    always_comb
    begin
        aluSel = cpuPkg::aluAdd;
        aluSelValid = 1'b1;
        case (aluOp)
            cpuPkg::aluOpSub: aluSel = cpuPkg::aluSub;
            cpuPkg::aluOpAdd: aluSel = cpuPkg::aluAdd;
            cpuPkg::aluOpFunct:
            begin
                case (funct)
                    cpuPkg::fnAdd: aluSel = cpuPkg::aluAdd;
                    cpuPkg::fnSub: aluSel = cpuPkg::aluSub;
                    cpuPkg::fnAnd: aluSel = cpuPkg::aluAnd;
                    cpuPkg::fnOr: aluSel = cpuPkg::aluOr;
                    cpuPkg::fnSlt: aluSel = cpuPkg::aluSlt;
                    default: aluSelValid = 1'b0; // Unknown funct gives 0
                endcase
            end
            default: aluSelValid = 1'b0;
        endcase
    end

    always_comb
    begin
        result = '0;
        if (aluSelValid)
        begin
            case (aluSel)
                cpuPkg::aluAdd: result = a + b;
                cpuPkg::aluSub: result = a - b;
                cpuPkg::aluAnd: result = a & b;
                cpuPkg::aluOr: result = a | b;
                cpuPkg::aluSlt: result = {{(cpuPkg::dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
                default: result = '0;
            endcase
        end
    end

    assign zero = (result == '0); // Drives beq

endmodule

`default_nettype wire

/* verilog/regFile.sv */
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input wire clk,
    input wire rstN,
    input wire [4:0] rdAddrA,
    input wire [4:0] rdAddrB,
    input wire [4:0] dbgAddr,
    input wire [4:0] wrAddr,
    input wire wrEn,
    input wire [cpuPkg::dataWidth-1:0] wrData,
    output logic [cpuPkg::dataWidth-1:0] rdDataA,
    output logic [cpuPkg::dataWidth-1:0] rdDataB,
    output logic [cpuPkg::dataWidth-1:0] dbgData
);

    logic [cpuPkg::dataWidth-1:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int k = 0; k < 32; k++)
                regs[k] <= '0;
        end
        else if (wrEn && (wrAddr != 5'd0)) // r0 stays zero
            regs[wrAddr] <= wrData;
    end

    // New value shows only after the write edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

/* verilog/instrMem.sv */
// Instruction memory with load port
`timescale 1ns/1ps
`default_nettype none

module instrMem (
    input wire clk,
    input wire we,
    input wire [cpuPkg::imemAddrBits-1:0] wrAddr,
    input wire [cpuPkg::dataWidth-1:0] wrData,
    input wire [cpuPkg::imemAddrBits-1:0] rdAddr,
    output cpuPkg::instrT instr
);

    logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::imemDepth];

    always_ff @(posedge clk)
    begin
        if (we) // Loader writes with core halted
            mem[wrAddr] <= wrData;
    end

    assign instr = mem[rdAddr]; // Fetch in the same cycle

endmodule

`default_nettype wire

/* verilog/dataMem.sv */
// Data memory
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input wire clk,
    input wire we,
    input wire re,
    input wire [cpuPkg::dmemAddrBits-1:0] addr,
    input wire [cpuPkg::dataWidth-1:0] wrData,
    output logic [cpuPkg::dataWidth-1:0] rdData
);

    logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::dmemDepth];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wrData;
    end

    // Quiet bus when no load is in flight
    assign rdData = re ? mem[addr] : '0;

endmodule

`default_nettype wire

/* verilog/cpuCore.sv */
// Single-cycle CPU core
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input wire clk,
    input wire rstN,
    input wire run,
    input wire imemWe,
    input wire [cpuPkg::imemAddrBits-1:0] imemAddr,
    input wire [cpuPkg::dataWidth-1:0] imemData,
    input wire [4:0] dbgRegAddr,
    output logic [cpuPkg::dataWidth-1:0] pc,
    output logic [cpuPkg::dataWidth-1:0] dbgRegData
);

    cpuPkg::instrT instr;

    logic regWrite;
    logic [1:0] aluOp;
    logic regDst;
    logic aluSrc;
    logic memWrite;
    logic memRead;
    logic memToReg;
    logic jump;
    logic branch;

    logic regWriteEn;
    logic memWriteEn;
    logic [4:0] wrReg;
    logic [cpuPkg::dataWidth-1:0] rdDataA;
    logic [cpuPkg::dataWidth-1:0] rdDataB;
    logic [cpuPkg::dataWidth-1:0] immExt;
    logic [cpuPkg::dataWidth-1:0] aluB;
    logic [cpuPkg::dataWidth-1:0] aluResult;
    logic aluZero;
    logic [cpuPkg::dataWidth-1:0] memData;
    logic [cpuPkg::dataWidth-1:0] wrData;
    logic [cpuPkg::dataWidth-1:0] pcPlus4;
    logic [cpuPkg::dataWidth-1:0] branchTarget;
    logic [cpuPkg::dataWidth-1:0] jumpTarget;
    logic [cpuPkg::dataWidth-1:0] pcNext;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            pc <= '0;
        else if (run) // One instruction per edge
            pc <= pcNext;
    end

    instrMem instrMem_i (
        .clk(clk),
        .we(imemWe),
        .wrAddr(imemAddr),
        .wrData(imemData),
        .rdAddr(pc[cpuPkg::imemAddrBits+1:2]), // Word index
        .instr(instr)
    );

    control control_i (
        .opCode(instr.r.opCode),
        .regWrite(regWrite),
        .aluOp(aluOp),
        .regDst(regDst),
        .aluSrc(aluSrc),
        .memWrite(memWrite),
        .memRead(memRead),
        .memToReg(memToReg),
        .jump(jump),
        .branch(branch)
    );

    // State only changes while running
    assign regWriteEn = regWrite & run;
    assign memWriteEn = memWrite & run;

    assign wrReg = regDst ? instr.r.rd : instr.r.rt;
    assign immExt = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign aluB = aluSrc ? immExt : rdDataB;
    assign wrData = memToReg ? memData : aluResult;

    regFile regFile_i (
        .clk(clk),
        .rstN(rstN),
        .rdAddrA(instr.r.rs),
        .rdAddrB(instr.r.rt),
        .dbgAddr(dbgRegAddr),
        .wrAddr(wrReg),
        .wrEn(regWriteEn),
        .wrData(wrData),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .dbgData(dbgRegData)
    );

    aluControl aluControl_i (
        .aluOp(aluOp),
        .funct(instr.r.funct),
        .a(rdDataA),
        .b(aluB),
        .result(aluResult),
        .zero(aluZero)
    );

    dataMem dataMem_i (
        .clk(clk),
        .we(memWriteEn),
        .re(memRead),
        .addr(aluResult[cpuPkg::dmemAddrBits+1:2]),
        .wrData(rdDataB), // Store source is rt
        .rdData(memData)
    );

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget = {pcPlus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};

    always_comb
    begin
        if (jump)
            pcNext = jumpTarget;
        else if (branch && aluZero) // beq taken
            pcNext = branchTarget;
        else
            pcNext = pcPlus4;
    end

endmodule

`default_nettype wire

/* dv/cpuCore_checker.sv */
// Core assertions
`timescale 1ns/1ps
`default_nettype none

module cpuCore_checker (
    input wire clk,
    input wire rstN,
    input wire run,
    input wire [31:0] pc,
    input wire regWriteEn,
    input wire memWriteEn
);

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    pcHold: assert property (@(posedge clk) disable iff (!rstN) !run |=> $stable(pc))
        else $error("pc moved while run was low");

    // Single-cycle core commits one kind of write
    oneWrite: assert property (@(posedge clk) disable iff (!rstN) !(regWriteEn && memWriteEn))
        else $error("register and memory written in the same cycle");

    pcAfterReset: assert property (@(posedge clk) !rstN |=> pc == '0)
        else $error("pc is not zero after reset");

endmodule

bind cpuCore cpuCore_checker cpuCore_checker_i (
    .clk(clk),
    .rstN(rstN),
    .run(run),
    .pc(pc),
    .regWriteEn(regWriteEn),
    .memWriteEn(memWriteEn)
);

`default_nettype wire

/* dv/cpuCoreTb.sv */
// CPU core testbench
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

    localparam int testCycles = 120; // Load, reset and run cycles of all tests together
    localparam int timeoutCycles = 4 * testCycles;

    logic clk = 1'b0;
    logic rstN;
    logic run;
    logic imemWe;
    logic [cpuPkg::imemAddrBits-1:0] imemAddr;
    logic [31:0] imemData;
    logic [4:0] dbgRegAddr;
    wire [31:0] pc;
    wire [31:0] dbgRegData;

    integer seed;
    int cycleCount = 0;
    logic [31:0] progWords [$];

    cpuCore cpuCore_i (
        .clk(clk),
        .rstN(rstN),
        .run(run),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dbgRegAddr(dbgRegAddr),
        .pc(pc),
        .dbgRegData(dbgRegData)
    );

    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
            failRun($sformatf("Timeout, run went past %0d clock cycles", timeoutCycles));
    end

    function automatic logic [31:0] sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        cpuPkg::instrT w;
        w.r = '{cpuPkg::opRType, rs, rt, rd, 5'd0, fn};
        return w;
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        cpuPkg::instrT w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic logic [31:0] jType(input logic [25:0] target);
        cpuPkg::instrT w;
        w.i = '{cpuPkg::opJ, target[25:21], target[20:16], target[15:0]}; // Word target
        return w;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (4) nextCycle();
        rstN = 1'b1;
    endtask

    task automatic runCycles(input int n);
        run = 1'b1;
        repeat (n) nextCycle(); // One commit per edge
        run = 1'b0;
    endtask

    // Write progWords with the core halted, restart from address 0, then run
    task automatic loadAndRun(input int cycles);
        imemWe = 1'b1;
        for (int k = 0; k < progWords.size(); k++)
        begin
            imemAddr = k[cpuPkg::imemAddrBits-1:0];
            imemData = progWords[k];
            nextCycle();
        end
        imemWe = 1'b0;
        applyReset();
        runCycles(cycles);
    endtask

    task automatic checkReg(input logic [4:0] addr, input logic [31:0] exp, input string what);
        dbgRegAddr = addr;
        #1; // Debug port is combinational
        assert (dbgRegData === exp)
        else failRun($sformatf("MISMATCH at %0t: %s, r%0d is %h, expected %h",
                               $time, what, addr, dbgRegData, exp));
    endtask

    task automatic checkPc(input logic [31:0] exp, input string what);
        assert (pc === exp)
        else failRun($sformatf("MISMATCH at %0t: %s, pc is %h, expected %h",
                               $time, what, pc, exp));
    endtask

    task automatic testRFormat();
        logic [31:0] rnd;
        logic [31:0] valA;
        logic [31:0] valB;
        rnd = $random(seed);
        valA = sext(rnd[15:0]);
        valB = sext(rnd[31:16]);
        progWords.delete();
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd1, 5'd0, rnd[15:0]));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd2, 5'd0, rnd[31:16]));
        progWords.push_back(rType(cpuPkg::fnAdd, 5'd3, 5'd1, 5'd2));
        progWords.push_back(rType(cpuPkg::fnSub, 5'd4, 5'd1, 5'd2));
        progWords.push_back(rType(cpuPkg::fnAnd, 5'd5, 5'd1, 5'd2));
        progWords.push_back(rType(cpuPkg::fnOr, 5'd6, 5'd1, 5'd2));
        progWords.push_back(rType(cpuPkg::fnSlt, 5'd7, 5'd1, 5'd2));
        progWords.push_back(rType(cpuPkg::fnSlt, 5'd8, 5'd2, 5'd1));
        progWords.push_back(rType(cpuPkg::fnAdd, 5'd0, 5'd1, 5'd2)); // Dropped write
        loadAndRun(9);
        checkReg(5'd3, valA + valB, "add");
        checkReg(5'd4, valA - valB, "sub");
        checkReg(5'd5, valA & valB, "and");
        checkReg(5'd6, valA | valB, "or");
        checkReg(5'd7, {31'd0, $signed(valA) < $signed(valB)}, "slt");
        checkReg(5'd8, {31'd0, $signed(valB) < $signed(valA)}, "slt swapped");
        checkReg(5'd0, 32'd0, "write to r0");
        checkPc(32'd36, "R-format end");
    endtask

    task automatic testImmediate();
        progWords.delete();
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h1234));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd2, 5'd1, 16'hfff0));
        progWords.push_back(iType(cpuPkg::opSubiu, 5'd3, 5'd1, 16'h0034));
        progWords.push_back(iType(cpuPkg::opSubiu, 5'd4, 5'd0, 16'hffff));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd5, 5'd0, 16'h8000));
        loadAndRun(5);
        checkReg(5'd1, 32'h0000_1234, "addiu positive");
        checkReg(5'd2, 32'h0000_1224, "addiu negative");
        checkReg(5'd3, 32'h0000_1200, "subiu positive");
        checkReg(5'd4, 32'h0000_0001, "subiu negative");
        checkReg(5'd5, 32'hffff_8000, "addiu sign bit");
    endtask

    task automatic testMemory();
        logic [31:0] rnd;
        rnd = $random(seed);
        progWords.delete();
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd1, 5'd0, rnd[15:0]));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd2, 5'd0, 16'h0010)); // Base 16
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd5, 5'd0, 16'h0055));
        progWords.push_back(iType(cpuPkg::opSw, 5'd1, 5'd2, 16'd8));
        progWords.push_back(iType(cpuPkg::opSw, 5'd5, 5'd2, 16'd4)); // Neighbour word
        progWords.push_back(iType(cpuPkg::opLw, 5'd3, 5'd2, 16'd8));
        progWords.push_back(iType(cpuPkg::opLw, 5'd6, 5'd2, 16'd4));
        loadAndRun(7);
        checkReg(5'd3, sext(rnd[15:0]), "lw after sw");
        checkReg(5'd6, 32'h0000_0055, "lw neighbour word");
        checkReg(5'd1, sext(rnd[15:0]), "store source");
        checkReg(5'd2, 32'h0000_0010, "base register");
    endtask

    task automatic testBranch();
        progWords.delete();
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd1, 5'd0, 16'd5));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd2, 5'd0, 16'd5));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd3, 5'd0, 16'd7));
        progWords.push_back(iType(cpuPkg::opBeq, 5'd2, 5'd1, 16'd1)); // Taken
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd4, 5'd0, 16'd1));
        progWords.push_back(iType(cpuPkg::opBeq, 5'd3, 5'd1, 16'd1)); // Falls through
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd5, 5'd0, 16'd1));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd6, 5'd0, 16'd2));
        loadAndRun(7);
        checkReg(5'd4, 32'd0, "marker after taken beq");
        checkReg(5'd5, 32'd1, "marker after untaken beq");
        checkReg(5'd6, 32'd2, "last instruction");
        checkPc(32'd32, "branch end");
    endtask

    task automatic testJump();
        logic [31:0] trace [10];
        // j 3, j 6, beq not taken, beq back to 0, then the loop again
        trace = '{32'd4, 32'd12, 32'd16, 32'd24, 32'd28, 32'd0, 32'd4, 32'd12, 32'd16, 32'd24};
        progWords.delete();
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd1, 5'd0, 16'd3));
        progWords.push_back(jType(26'd3));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd2, 5'd0, 16'd9));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd3, 5'd0, 16'd4));
        progWords.push_back(jType(26'd6));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd4, 5'd0, 16'd1));
        progWords.push_back(iType(cpuPkg::opBeq, 5'd3, 5'd1, 16'd2));
        progWords.push_back(iType(cpuPkg::opBeq, 5'd0, 5'd0, 16'hfff8)); // Back by 8 words
        loadAndRun(0);
        for (int k = 0; k < 10; k++)
        begin
            runCycles(1);
            checkPc(trace[k], $sformatf("jump trace step %0d", k));
        end
        checkReg(5'd2, 32'd0, "marker after j");
        checkReg(5'd4, 32'd0, "second marker after j");
        checkReg(5'd3, 32'd4, "jump target");
    endtask

    task automatic testHoldUnknown();
        progWords.delete();
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h0077));
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd2, 5'd0, 16'h0011));
        progWords.push_back({6'd63, 5'd1, 5'd2, 5'd3, 5'd0, cpuPkg::fnAdd}); // Undefined
        progWords.push_back(iType(cpuPkg::opAddiu, 5'd3, 5'd0, 16'h0022));
        loadAndRun(1);
        repeat (5) nextCycle(); // Halted on a register write
        checkPc(32'd4, "hold");
        checkReg(5'd2, 32'd0, "hold");
        runCycles(1);
        checkReg(5'd2, 32'h0000_0011, "resume");
        runCycles(1);
        checkPc(32'd12, "unknown opcode");
        checkReg(5'd1, 32'h0000_0077, "unknown opcode r1");
        checkReg(5'd2, 32'h0000_0011, "unknown opcode r2");
        checkReg(5'd3, 32'd0, "unknown opcode r3");
        runCycles(1);
        checkReg(5'd3, 32'h0000_0022, "after unknown opcode");
    endtask

    initial
    begin
        rstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        dbgRegAddr = '0;
        seed = 32'h5467;
        applyReset();
        testRFormat();
        testImmediate();
        testMemory();
        testBranch();
        testJump();
        testHoldUnknown();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* cpuCore.f */
common/cpuPkg.sv
control/control.sv
verilog/aluControl.sv
verilog/regFile.sv
verilog/instrMem.sv
verilog/dataMem.sv
verilog/cpuCore.sv
dv/cpuCore_checker.sv
dv/cpuCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuCoreTb -Mdir obj_dir -f cpuCore.f

# The log decides the result, so a stopped simulation must not end the script here
./obj_dir/VcpuCoreTb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
